// ==== hw/tex_cache_pkg.sv ====
/*
 * texture cache shared constants
 * 64x64 texture of 8-bit pixels in 4x4 blocks, queue and lookahead sizes
 */
package tex_cache_pkg;

	// --------------------------------------------------------------------------
	// texture geometry
	// --------------------------------------------------------------------------
	// pixel coordinate, same for x and y
	localparam int COORD_W = 6;
	localparam int PIX_W = 8;
	// log2 of the block edge
	localparam int BLK_SIZE = 2;
	localparam int BLK_W = COORD_W - BLK_SIZE;

	// --------------------------------------------------------------------------
	// tag table and data RAM
	// --------------------------------------------------------------------------
	// index is {blk_y[1:0], blk_x[1:0]}
	localparam int INDEX_W = 4;
	localparam int LINES = 1 << INDEX_W;
	// upper bits of block x and y
	localparam int TAG_W = 4;
	// one beat is one block row, pixel i in byte i
	localparam int BEAT_W = PIX_W << BLK_SIZE;
	localparam int BEATS_PER_BLK = 1 << BLK_SIZE;
	// data RAM word address {index, row}
	localparam int DATA_AW = INDEX_W + BLK_SIZE;

	// --------------------------------------------------------------------------
	// queues and fetch control
	// --------------------------------------------------------------------------
	localparam int LOOKAHEAD_NUM = 2;
	// room for LOOKAHEAD_NUM whole blocks
	localparam int RFIFO_DEPTH_LOG = 3;
	localparam int REQ_DEPTH_LOG = 2;
	localparam int USER_W = 4;
	localparam logic [PIX_W-1:0] BORDER_PIXEL = '0;

	// block store FSM encodings
	localparam logic [1:0] ST_IDLE = 2'd0;
	localparam logic [1:0] ST_FILL = 2'd1;
	localparam logic [1:0] ST_READ = 2'd2;
	localparam logic [1:0] ST_RESP = 2'd3;

endpackage

// ==== hw/tex_fifo.sv ====
/*
 * first-word-fall-through queue
 * circular buffer, head word is visible on pop_data while not empty
 */
module tex_fifo #(
	parameter int DEPTH_LOG = 2,
	parameter int DATA_W = 8
) (
	input  logic              clk,
	input  logic              reset,
	input  logic              push,
	input  logic [DATA_W-1:0] push_data,
	output logic              full,
	input  logic              pop,
	output logic [DATA_W-1:0] pop_data,
	output logic              empty
);

	logic [DATA_W-1:0] mem [0:(1 << DEPTH_LOG)-1];
	logic [DEPTH_LOG-1:0] wr_ptr;
	logic [DEPTH_LOG-1:0] rd_ptr;
	logic [DEPTH_LOG:0] count;
	logic do_push;
	logic do_pop;

	assign do_push = push && !full;
	assign do_pop = pop && !empty;
	// msb of the count is set only at full depth
	assign full = count[DEPTH_LOG];
	assign empty = (count == '0);
	assign pop_data = mem[rd_ptr];

	always_ff @(posedge clk) begin
		if (do_push) begin
			mem[wr_ptr] <= push_data;
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
		end else begin
			if (do_push) begin
				wr_ptr <= wr_ptr + 1'b1;
			end
			if (do_pop) begin
				rd_ptr <= rd_ptr + 1'b1;
			end
			if (do_push && !do_pop) begin
				count <= count + 1'b1;
			end else if (do_pop && !do_push) begin
				count <= count - 1'b1;
			end
		end
	end

	a_no_overflow: assert property (@(posedge clk) disable iff (reset) push |-> !full)
		else $error("tex_fifo push while full");
	a_no_underflow: assert property (@(posedge clk) disable iff (reset) pop |-> !empty)
		else $error("tex_fifo pop while empty");

endmodule

// ==== hw/tex_tag_lookup.sv ====
/*
 * tag stage: direct-mapped tag table with hit, miss and range decision
 * plus the sequencer that invalidates every line on reset and on clear
 */
module tex_tag_lookup (
	input  logic                                clk,
	input  logic                                reset,
	input  logic                                clear_start,
	output logic                                clear_busy,
	input  logic [tex_cache_pkg::COORD_W:0]     param_width,
	input  logic [tex_cache_pkg::COORD_W:0]     param_height,
	input  logic [tex_cache_pkg::COORD_W-1:0]   req_x,
	input  logic [tex_cache_pkg::COORD_W-1:0]   req_y,
	input  logic [tex_cache_pkg::USER_W-1:0]    req_user,
	input  logic                                req_valid,
	output logic                                req_ready,
	output logic [tex_cache_pkg::COORD_W-1:0]   lookup_x,
	output logic [tex_cache_pkg::COORD_W-1:0]   lookup_y,
	output logic [tex_cache_pkg::USER_W-1:0]    lookup_user,
	output logic                                lookup_hit,
	output logic                                lookup_range,
	output logic                                lookup_valid,
	input  logic                                lookup_accept,
	output logic                                stat_hit,
	output logic                                stat_miss,
	output logic                                stat_range
);

	logic [tex_cache_pkg::TAG_W-1:0] tag_mem [0:tex_cache_pkg::LINES-1];
	logic [tex_cache_pkg::LINES-1:0] line_valid;
	logic [tex_cache_pkg::INDEX_W-1:0] req_index;
	logic [tex_cache_pkg::INDEX_W-1:0] clear_idx;
	logic [tex_cache_pkg::TAG_W-1:0] req_tag;
	logic req_out;
	logic req_hit;
	logic accept;
	logic lookup_take;
	// sweep still owed after reset
	logic init_pend;

	// --------------------------------------------------------------------------
	// address split and decision
	// --------------------------------------------------------------------------
	assign req_index = {req_y[tex_cache_pkg::BLK_SIZE +: tex_cache_pkg::INDEX_W/2],
		req_x[tex_cache_pkg::BLK_SIZE +: tex_cache_pkg::INDEX_W/2]};
	assign req_tag = {req_y[tex_cache_pkg::COORD_W-1 -: tex_cache_pkg::TAG_W/2],
		req_x[tex_cache_pkg::COORD_W-1 -: tex_cache_pkg::TAG_W/2]};
	assign req_out = ({1'b0, req_x} >= param_width) || ({1'b0, req_y} >= param_height);
	assign req_hit = line_valid[req_index] && (tag_mem[req_index] == req_tag);

	// one-entry output stage, refilled in the cycle it drains
	assign req_ready = !clear_busy && !init_pend && (!lookup_valid || lookup_accept);
	assign accept = req_valid && req_ready;
	assign lookup_take = lookup_valid && lookup_accept;
	assign stat_hit = lookup_take && lookup_hit;
	assign stat_range = lookup_take && lookup_range;
	assign stat_miss = lookup_take && !lookup_hit && !lookup_range;

	// tag written at the miss, so a following request to the block hits
	always_ff @(posedge clk) begin
		if (clear_busy) begin
			line_valid[clear_idx] <= 1'b0;
		end else if (accept && !req_out && !req_hit) begin
			line_valid[req_index] <= 1'b1;
			tag_mem[req_index] <= req_tag;
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			lookup_valid <= 1'b0;
		end else if (accept) begin
			lookup_valid <= 1'b1;
		end else if (lookup_accept) begin
			lookup_valid <= 1'b0;
		end
	end

	always_ff @(posedge clk) begin
		if (accept) begin
			lookup_x <= req_x;
			lookup_y <= req_y;
			lookup_user <= req_user;
			lookup_hit <= req_hit && !req_out;
			lookup_range <= req_out;
		end
	end

	// --------------------------------------------------------------------------
	// clear sequencer, one line per cycle
	// --------------------------------------------------------------------------
	always_ff @(posedge clk) begin
		if (reset) begin
			init_pend <= 1'b1;
			clear_busy <= 1'b0;
			clear_idx <= '0;
		end else if (clear_busy) begin
			clear_idx <= clear_idx + 1'b1;
			if (&clear_idx) begin
				clear_busy <= 1'b0;
			end
		end else if (init_pend || clear_start) begin
			init_pend <= 1'b0;
			clear_busy <= 1'b1;
		end
	end

endmodule

// ==== hw/tex_fetch_limiter.sv ====
/*
 * lookahead limiter
 * counts block fetches in flight and gates the memory address port
 */
module tex_fetch_limiter (
	input  logic clk,
	input  logic reset,
	input  logic fetch_issue,
	input  logic block_done,
	output logic fetch_allow
);

	// fetches issued whose last beat has not left the read queue
	logic [$clog2(tex_cache_pkg::LOOKAHEAD_NUM + 1)-1:0] out_cnt;

	assign fetch_allow = (int'(out_cnt) < tex_cache_pkg::LOOKAHEAD_NUM);

	always_ff @(posedge clk) begin
		if (reset) begin
			out_cnt <= '0;
		end else if (fetch_issue && !block_done) begin
			out_cnt <= out_cnt + 1'b1;
		end else if (block_done && !fetch_issue) begin
			out_cnt <= out_cnt - 1'b1;
		end
	end

	a_count_bound: assert property (@(posedge clk) disable iff (reset)
		int'(out_cnt) <= tex_cache_pkg::LOOKAHEAD_NUM)
		else $error("lookahead count above limit");

	// a block can only complete after its fetch was issued
	a_done_has_fetch: assert property (@(posedge clk) disable iff (reset)
		block_done |-> (out_cnt != '0) || fetch_issue)
		else $error("block completion with nothing outstanding");

endmodule

// ==== hw/tex_block_store.sv ====
/*
 * in-order block store: fills lines from memory beats on a miss
 * and returns one pixel per request, border value for range requests
 */
module tex_block_store (
	input  logic                                clk,
	input  logic                                reset,
	input  logic                                req_empty,
	output logic                                req_pop,
	input  logic [tex_cache_pkg::COORD_W-1:0]   req_x,
	input  logic [tex_cache_pkg::COORD_W-1:0]   req_y,
	input  logic [tex_cache_pkg::USER_W-1:0]    req_user,
	input  logic                                req_hit,
	input  logic                                req_range,
	input  logic                                beat_empty,
	output logic                                beat_pop,
	input  logic [tex_cache_pkg::BEAT_W-1:0]    beat_data,
	input  logic                                beat_last,
	output logic [tex_cache_pkg::PIX_W-1:0]     rsp_data,
	output logic [tex_cache_pkg::USER_W-1:0]    rsp_user,
	output logic                                rsp_valid
);

	logic [tex_cache_pkg::BEAT_W-1:0] data_mem [0:(1 << tex_cache_pkg::DATA_AW)-1];
	logic [1:0] state;
	logic [tex_cache_pkg::BLK_SIZE-1:0] beat_cnt;
	logic [tex_cache_pkg::INDEX_W-1:0] line_idx;
	logic [tex_cache_pkg::BEAT_W-1:0] rd_word;
	logic [tex_cache_pkg::BLK_SIZE-1:0] pix_q;
	logic [tex_cache_pkg::USER_W-1:0] user_q;
	logic last_slot;
	logic take_range;
	logic do_read;

	assign line_idx = {req_y[tex_cache_pkg::BLK_SIZE +: tex_cache_pkg::INDEX_W/2],
		req_x[tex_cache_pkg::BLK_SIZE +: tex_cache_pkg::INDEX_W/2]};
	assign last_slot = (int'(beat_cnt) == tex_cache_pkg::BEATS_PER_BLK - 1);
	assign take_range = (state == tex_cache_pkg::ST_IDLE) && !req_empty && req_range;
	// hits read straight from idle, misses read once the fill is done
	assign do_read = ((state == tex_cache_pkg::ST_IDLE) && !req_empty && req_hit) ||
		(state == tex_cache_pkg::ST_READ);
	assign req_pop = do_read || take_range;
	assign beat_pop = (state == tex_cache_pkg::ST_FILL) && !beat_empty;

	always_ff @(posedge clk) begin
		if (beat_pop) begin
			data_mem[{line_idx, beat_cnt}] <= beat_data;
		end
		if (do_read) begin
			rd_word <= data_mem[{line_idx, req_y[tex_cache_pkg::BLK_SIZE-1:0]}];
			pix_q <= req_x[tex_cache_pkg::BLK_SIZE-1:0];
			user_q <= req_user;
		end
	end

	// output register, pixel picked from the row word
	always_ff @(posedge clk) begin
		if (state == tex_cache_pkg::ST_RESP) begin
			rsp_data <= rd_word[pix_q*tex_cache_pkg::PIX_W +: tex_cache_pkg::PIX_W];
			rsp_user <= user_q;
		end else if (take_range) begin
			rsp_data <= tex_cache_pkg::BORDER_PIXEL;
			rsp_user <= req_user;
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			state <= tex_cache_pkg::ST_IDLE;
			beat_cnt <= '0;
			rsp_valid <= 1'b0;
		end else begin
			rsp_valid <= (state == tex_cache_pkg::ST_RESP) || take_range;
			case (state)
				tex_cache_pkg::ST_IDLE: begin
					if (!req_empty && !req_range) begin
						state <= req_hit ? tex_cache_pkg::ST_RESP : tex_cache_pkg::ST_FILL;
					end
				end
				tex_cache_pkg::ST_FILL: begin
					if (beat_pop) begin
						beat_cnt <= beat_cnt + 1'b1;
						if (last_slot) begin
							state <= tex_cache_pkg::ST_READ;
						end
					end
				end
				tex_cache_pkg::ST_READ: state <= tex_cache_pkg::ST_RESP;
				default: state <= tex_cache_pkg::ST_IDLE;
			endcase
		end
	end

	// memory framing must line up with the fill counter
	a_last_on_fourth: assert property (@(posedge clk) disable iff (reset)
		beat_pop |-> (beat_last == last_slot))
		else $error("beat_last out of step with block fill");

endmodule

// ==== hw/tex_cache_lookahead.sv ====
/*
 * texture read cache with lookahead block fetch
 * tag stage, request/miss/beat queues, fetch limiter and block store
 */
module tex_cache_lookahead (
	input  logic                                clk,
	input  logic                                reset,
	input  logic [tex_cache_pkg::COORD_W-1:0]   req_x,
	input  logic [tex_cache_pkg::COORD_W-1:0]   req_y,
	input  logic [tex_cache_pkg::USER_W-1:0]    req_user,
	input  logic                                req_valid,
	output logic                                req_ready,
	output logic [tex_cache_pkg::PIX_W-1:0]     rsp_data,
	output logic [tex_cache_pkg::USER_W-1:0]    rsp_user,
	output logic                                rsp_valid,
	output logic [tex_cache_pkg::BLK_W-1:0]     mem_blk_x,
	output logic [tex_cache_pkg::BLK_W-1:0]     mem_blk_y,
	output logic                                mem_arvalid,
	input  logic                                mem_arready,
	input  logic [tex_cache_pkg::BEAT_W-1:0]    mem_rdata,
	input  logic                                mem_rlast,
	input  logic                                mem_rvalid,
	input  logic [tex_cache_pkg::COORD_W:0]     param_width,
	input  logic [tex_cache_pkg::COORD_W:0]     param_height,
	input  logic                                clear_start,
	output logic                                clear_busy,
	output logic                                stat_hit,
	output logic                                stat_miss,
	output logic                                stat_range
);

	logic [tex_cache_pkg::COORD_W-1:0] lookup_x;
	logic [tex_cache_pkg::COORD_W-1:0] lookup_y;
	logic [tex_cache_pkg::USER_W-1:0] lookup_user;
	logic lookup_hit;
	logic lookup_range;
	logic lookup_valid;
	logic lookup_accept;
	logic lookup_miss;
	logic req_full;
	logic req_empty;
	logic req_pop;
	logic [tex_cache_pkg::COORD_W-1:0] rq_x;
	logic [tex_cache_pkg::COORD_W-1:0] rq_y;
	logic [tex_cache_pkg::USER_W-1:0] rq_user;
	logic rq_hit;
	logic rq_range;
	logic miss_full;
	logic miss_empty;
	logic miss_pop;
	logic fetch_allow;
	logic beat_empty;
	logic beat_pop;
	logic [tex_cache_pkg::BEAT_W-1:0] beat_data;
	logic beat_last;

	// --------------------------------------------------------------------------
	// lookup hand-off, both queue pushes in one cycle
	// --------------------------------------------------------------------------
	assign lookup_miss = !lookup_hit && !lookup_range;
	assign lookup_accept = lookup_valid && !req_full && (!lookup_miss || !miss_full);
	assign miss_pop = mem_arvalid && mem_arready;
	assign mem_arvalid = !miss_empty && fetch_allow;

	tex_tag_lookup u_tag (
		.clk(clk), .reset(reset), .clear_start(clear_start), .clear_busy(clear_busy),
		.param_width(param_width), .param_height(param_height),
		.req_x(req_x), .req_y(req_y), .req_user(req_user),
		.req_valid(req_valid), .req_ready(req_ready),
		.lookup_x(lookup_x), .lookup_y(lookup_y), .lookup_user(lookup_user),
		.lookup_hit(lookup_hit), .lookup_range(lookup_range),
		.lookup_valid(lookup_valid), .lookup_accept(lookup_accept),
		.stat_hit(stat_hit), .stat_miss(stat_miss), .stat_range(stat_range)
	);

	tex_fifo #(
		.DEPTH_LOG(tex_cache_pkg::REQ_DEPTH_LOG),
		.DATA_W(tex_cache_pkg::USER_W + 2 + 2 * tex_cache_pkg::COORD_W)
	) u_req_fifo (
		.clk(clk), .reset(reset),
		.push(lookup_accept),
		.push_data({lookup_user, lookup_hit, lookup_range, lookup_x, lookup_y}),
		.full(req_full), .pop(req_pop),
		.pop_data({rq_user, rq_hit, rq_range, rq_x, rq_y}), .empty(req_empty)
	);

	// block address only, pixel bits dropped
	tex_fifo #(
		.DEPTH_LOG(tex_cache_pkg::REQ_DEPTH_LOG),
		.DATA_W(2 * tex_cache_pkg::BLK_W)
	) u_miss_fifo (
		.clk(clk), .reset(reset),
		.push(lookup_accept && lookup_miss),
		.push_data({lookup_x[tex_cache_pkg::COORD_W-1 -: tex_cache_pkg::BLK_W],
			lookup_y[tex_cache_pkg::COORD_W-1 -: tex_cache_pkg::BLK_W]}),
		.full(miss_full), .pop(miss_pop),
		.pop_data({mem_blk_x, mem_blk_y}), .empty(miss_empty)
	);

	// room is guaranteed by the limiter, so beats push unconditionally
	tex_fifo #(
		.DEPTH_LOG(tex_cache_pkg::RFIFO_DEPTH_LOG),
		.DATA_W(1 + tex_cache_pkg::BEAT_W)
	) u_beat_fifo (
		.clk(clk), .reset(reset),
		.push(mem_rvalid), .push_data({mem_rlast, mem_rdata}), .full(),
		.pop(beat_pop), .pop_data({beat_last, beat_data}), .empty(beat_empty)
	);

	tex_fetch_limiter u_limiter (
		.clk(clk), .reset(reset),
		.fetch_issue(miss_pop), .block_done(beat_pop && beat_last),
		.fetch_allow(fetch_allow)
	);

	tex_block_store u_store (
		.clk(clk), .reset(reset),
		.req_empty(req_empty), .req_pop(req_pop),
		.req_x(rq_x), .req_y(rq_y), .req_user(rq_user),
		.req_hit(rq_hit), .req_range(rq_range),
		.beat_empty(beat_empty), .beat_pop(beat_pop),
		.beat_data(beat_data), .beat_last(beat_last),
		.rsp_data(rsp_data), .rsp_user(rsp_user), .rsp_valid(rsp_valid)
	);

endmodule

// ==== bench/tex_mem_model.sv ====
/*
 * behavioral block memory for the texture cache testbench
 * random address ready, whole blocks returned in order after 2 to 9 cycles
 */
module tex_mem_model (
	input  logic                             clk,
	input  logic                             reset,
	input  logic [tex_cache_pkg::BLK_W-1:0]  mem_blk_x,
	input  logic [tex_cache_pkg::BLK_W-1:0]  mem_blk_y,
	input  logic                             mem_arvalid,
	output logic                             mem_arready,
	output logic [tex_cache_pkg::BEAT_W-1:0] mem_rdata,
	output logic                             mem_rlast,
	output logic                             mem_rvalid
);

	int cycle;
	// row being sent, -1 while idle
	int row;
	int due_q[$];
	int bx_q[$];
	int by_q[$];

	// row k of block (bx, by), pixel i in byte i
	function automatic logic [tex_cache_pkg::BEAT_W-1:0] block_row(input int bx, input int by,
		input int k);
		logic [tex_cache_pkg::BEAT_W-1:0] w;
		int v;
		w = '0;
		for (int i = 0; i < tex_cache_pkg::BEATS_PER_BLK; i++) begin
			v = (5 * (bx * 4 + i) + 11 * (by * 4 + k)) % 256;
			w[i * tex_cache_pkg::PIX_W +: tex_cache_pkg::PIX_W] = v[tex_cache_pkg::PIX_W-1:0];
		end
		return w;
	endfunction

	initial begin
		cycle = 0;
		row = -1;
		mem_arready = 1'b0;
		mem_rvalid = 1'b0;
		mem_rlast = 1'b0;
		mem_rdata = '0;
		forever begin
			@(posedge clk);
			cycle++;
			if (!reset && mem_arvalid && mem_arready) begin
				bx_q.push_back(int'(mem_blk_x));
				by_q.push_back(int'(mem_blk_y));
				due_q.push_back(cycle + 2 + int'($urandom % 8));
			end
			// outputs change on the falling edge
			@(negedge clk);
			mem_arready = ($urandom % 3) != 0;
			mem_rvalid = 1'b0;
			mem_rlast = 1'b0;
			if (row < 0 && due_q.size() != 0 && cycle >= due_q[0]) begin
				row = 0;
			end
			if (row >= 0) begin
				mem_rvalid = 1'b1;
				mem_rdata = block_row(bx_q[0], by_q[0], row);
				mem_rlast = (row == tex_cache_pkg::BEATS_PER_BLK - 1);
				if (mem_rlast) begin
					void'(bx_q.pop_front());
					void'(by_q.pop_front());
					void'(due_q.pop_front());
					row = -1;
				end else begin
					row++;
				end
			end
		end
	end

endmodule

// ==== bench/tb_tex_cache.sv ====
/*
 * testbench for the texture cache with lookahead fetch
 * directed and random requests checked against a pixel and tag reference
 */
module tb_tex_cache;

	localparam int NUM_RANDOM = 400;
	localparam int TIMEOUT_CYC = NUM_RANDOM * 40 + 200;

	logic clk;
	logic reset;
	logic [tex_cache_pkg::COORD_W-1:0] req_x;
	logic [tex_cache_pkg::COORD_W-1:0] req_y;
	logic [tex_cache_pkg::USER_W-1:0] req_user;
	logic req_valid;
	logic req_ready;
	logic [tex_cache_pkg::PIX_W-1:0] rsp_data;
	logic [tex_cache_pkg::USER_W-1:0] rsp_user;
	logic rsp_valid;
	logic [tex_cache_pkg::BLK_W-1:0] mem_blk_x;
	logic [tex_cache_pkg::BLK_W-1:0] mem_blk_y;
	logic mem_arvalid;
	logic mem_arready;
	logic [tex_cache_pkg::BEAT_W-1:0] mem_rdata;
	logic mem_rlast;
	logic mem_rvalid;
	logic [tex_cache_pkg::COORD_W:0] param_width;
	logic [tex_cache_pkg::COORD_W:0] param_height;
	logic clear_start;
	logic clear_busy;
	logic stat_hit;
	logic stat_miss;
	logic stat_range;

	// reference tag table
	bit [tex_cache_pkg::LINES-1:0] ref_valid;
	int ref_tag [0:tex_cache_pkg::LINES-1];
	logic [tex_cache_pkg::PIX_W-1:0] exp_pix[$];
	logic [tex_cache_pkg::USER_W-1:0] exp_user[$];
	// one-hot {range, miss, hit}
	logic [2:0] exp_kind[$];
	// block addresses of predicted misses, in fetch order
	logic [tex_cache_pkg::BLK_W-1:0] exp_blk_x[$];
	logic [tex_cache_pkg::BLK_W-1:0] exp_blk_y[$];
	int value_errs = 0;
	int other_errs = 0;
	int cycles = 0;
	int ref_hits = 0;
	int ref_misses = 0;
	int ref_ranges = 0;
	int dut_hits = 0;
	int dut_misses = 0;
	int dut_ranges = 0;
	int fetch_total = 0;
	int last_total = 0;
	int outstanding = 0;

	tex_cache_lookahead u_dut (.*);

	tex_mem_model u_mem (
		.clk(clk), .reset(reset), .mem_blk_x(mem_blk_x), .mem_blk_y(mem_blk_y),
		.mem_arvalid(mem_arvalid), .mem_arready(mem_arready), .mem_rdata(mem_rdata),
		.mem_rlast(mem_rlast), .mem_rvalid(mem_rvalid)
	);

	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	// texel value, zero outside the programmed size
	function automatic logic [tex_cache_pkg::PIX_W-1:0] expected_pixel(input int x, input int y,
		input int w, input int h);
		int v;
		if (x >= w || y >= h) begin
			return '0;
		end
		v = (5 * x + 11 * y) % 256;
		return v[tex_cache_pkg::PIX_W-1:0];
	endfunction

	task automatic check_pixel(input string name, input logic [tex_cache_pkg::PIX_W-1:0] exp_v,
		input logic [tex_cache_pkg::PIX_W-1:0] act_v);
		if (act_v !== exp_v) begin
			value_errs++;
			$display("Fail at %0t: %s expected 0x%0h got 0x%0h", $time, name, exp_v, act_v);
		end
	endtask

	task automatic check_user(input string name, input logic [tex_cache_pkg::USER_W-1:0] exp_v,
		input logic [tex_cache_pkg::USER_W-1:0] act_v);
		if (act_v !== exp_v) begin
			value_errs++;
			$display("Fail at %0t: %s expected 0x%0h got 0x%0h", $time, name, exp_v, act_v);
		end
	endtask

	task automatic check_block(input string name, input logic [tex_cache_pkg::BLK_W-1:0] exp_v,
		input logic [tex_cache_pkg::BLK_W-1:0] act_v);
		if (act_v !== exp_v) begin
			value_errs++;
			$display("Fail at %0t: %s expected %0d got %0d", $time, name, exp_v, act_v);
		end
	endtask

	task automatic check_kind(input string name, input logic [2:0] exp_v, input logic [2:0] act_v);
		if (act_v !== exp_v) begin
			value_errs++;
			$display("Fail at %0t: %s expected %b got %b", $time, name, exp_v, act_v);
		end
	endtask

	task automatic check_count(input string name, input int exp_v, input int act_v);
		if (act_v != exp_v) begin
			value_errs++;
			$display("Fail at %0t: %s expected %0d got %0d", $time, name, exp_v, act_v);
		end
	endtask

	// direct-mapped rule: index {by[1:0], bx[1:0]}, tag from the upper block bits
	task automatic predict_request();
		int bx;
		int by;
		int idx;
		int tag;
		logic [2:0] kind;
		bx = int'(req_x) / 4;
		by = int'(req_y) / 4;
		idx = (by % 4) * 4 + bx % 4;
		tag = (by / 4) * 4 + bx / 4;
		if (int'(req_x) >= int'(param_width) || int'(req_y) >= int'(param_height)) begin
			kind = 3'b100;
			ref_ranges++;
		end else if (ref_valid[idx] && ref_tag[idx] == tag) begin
			kind = 3'b001;
			ref_hits++;
		end else begin
			kind = 3'b010;
			ref_misses++;
			ref_valid[idx] = 1'b1;
			ref_tag[idx] = tag;
			exp_blk_x.push_back(bx[tex_cache_pkg::BLK_W-1:0]);
			exp_blk_y.push_back(by[tex_cache_pkg::BLK_W-1:0]);
		end
		exp_kind.push_back(kind);
		exp_user.push_back(req_user);
		exp_pix.push_back(expected_pixel(int'(req_x), int'(req_y), int'(param_width),
			int'(param_height)));
	endtask

	// ------------------------------------------------------------------------
	// monitor and compare
	// ------------------------------------------------------------------------
	always @(posedge clk) begin
		if (reset) begin
			ref_valid = '0;
		end else begin
			if (clear_start) begin
				ref_valid = '0;
			end
			if (req_valid && req_ready) begin
				predict_request();
			end
			if (mem_arvalid && mem_arready) begin
				fetch_total++;
				outstanding++;
				if (exp_blk_x.size() == 0) begin
					other_errs++;
					$display("block fetch at %0t with no miss pending", $time);
				end else begin
					check_block("mem_blk_x", exp_blk_x.pop_front(), mem_blk_x);
					check_block("mem_blk_y", exp_blk_y.pop_front(), mem_blk_y);
				end
			end
			if (mem_rvalid && mem_rlast) begin
				last_total++;
				outstanding--;
			end
			if (outstanding > tex_cache_pkg::LOOKAHEAD_NUM) begin
				other_errs++;
				$display("more than %0d block fetches in flight at %0t",
					tex_cache_pkg::LOOKAHEAD_NUM, $time);
			end
			if (clear_busy && req_ready) begin
				other_errs++;
				$display("req_ready high during tag clear at %0t", $time);
			end
			if (rsp_valid) begin
				if (exp_pix.size() == 0) begin
					other_errs++;
					$display("response at %0t with no request outstanding", $time);
				end else begin
					check_pixel("rsp_data", exp_pix.pop_front(), rsp_data);
					check_user("rsp_user", exp_user.pop_front(), rsp_user);
				end
			end
			if (stat_hit || stat_miss || stat_range) begin
				dut_hits += int'(stat_hit);
				dut_misses += int'(stat_miss);
				dut_ranges += int'(stat_range);
				if (exp_kind.size() == 0) begin
					other_errs++;
					$display("lookup strobe at %0t with no request accepted", $time);
				end else begin
					check_kind("stat strobes", exp_kind.pop_front(), {stat_range, stat_miss, stat_hit});
				end
			end
		end
	end

	always @(posedge clk) begin
		cycles++;
		if (cycles >= TIMEOUT_CYC) begin
			$display("timeout after %0d cycles with %0d responses owed", cycles, exp_pix.size());
			$display("Simulation FAILED");
			$finish;
		end
	end

	// ------------------------------------------------------------------------
	// stimulus tasks
	// ------------------------------------------------------------------------
	task automatic send_request(input int x, input int y, input int user);
		@(negedge clk);
		req_x = x[tex_cache_pkg::COORD_W-1:0];
		req_y = y[tex_cache_pkg::COORD_W-1:0];
		req_user = user[tex_cache_pkg::USER_W-1:0];
		req_valid = 1'b1;
		@(posedge clk);
		while (!req_ready) begin
			@(posedge clk);
		end
	endtask

	task automatic drop_request();
		@(negedge clk);
		req_valid = 1'b0;
	endtask

	task automatic wait_drain();
		@(negedge clk);
		while (exp_pix.size() != 0 || exp_kind.size() != 0) begin
			@(negedge clk);
		end
	endtask

	// counts busy cycles until req_ready, strobes must stay quiet
	task automatic watch_clear(input string what);
		int n;
		n = 0;
		@(posedge clk);
		while (!req_ready && n < 40) begin
			n += int'(clear_busy);
			if (rsp_valid || mem_arvalid || stat_hit || stat_miss || stat_range) begin
				other_errs++;
				$display("outputs active during %s at %0t", what, $time);
			end
			@(posedge clk);
		end
		check_count({what, " busy cycles"}, tex_cache_pkg::LINES, n);
		if (!req_ready) begin
			other_errs++;
			$display("req_ready never rose after %s", what);
		end
	endtask

	initial begin
		int f0;
		int x;
		int y;
		void'($urandom(37478));
		reset = 1'b1;
		req_x = '0;
		req_y = '0;
		req_user = '0;
		req_valid = 1'b0;
		param_width = 7'd64;
		param_height = 7'd64;
		clear_start = 1'b0;
		repeat (8) @(posedge clk);
		@(negedge clk);
		reset = 1'b0;
		watch_clear("reset clear");

		// two requests in one new block, one fetch
		f0 = fetch_total;
		send_request(21, 37, 1);
		send_request(22, 39, 2);
		drop_request();
		wait_drain();
		check_count("fetches for one block", 1, fetch_total - f0);

		// out of range, no fetch
		param_width = 7'd40;
		param_height = 7'd48;
		f0 = fetch_total;
		send_request(40, 10, 3);
		send_request(5, 48, 4);
		send_request(63, 63, 5);
		drop_request();
		wait_drain();
		check_count("fetches for range requests", 0, fetch_total - f0);

		// random stream, mostly inside a small window for some reuse
		param_width = 7'd60;
		param_height = 7'd52;
		for (int n = 0; n < NUM_RANDOM; n++) begin
			if ($urandom % 4 == 0) begin
				x = int'($urandom % 64);
				y = int'($urandom % 64);
			end else begin
				x = 16 + int'($urandom % 24);
				y = 8 + int'($urandom % 16);
			end
			send_request(x, y, n);
			if ($urandom % 5 == 0) begin
				drop_request();
			end
		end
		drop_request();
		wait_drain();

		// cached block misses again after a clear
		param_width = 7'd64;
		param_height = 7'd64;
		send_request(2, 3, 6);
		send_request(2, 3, 7);
		drop_request();
		wait_drain();
		@(negedge clk);
		clear_start = 1'b1;
		@(negedge clk);
		clear_start = 1'b0;
		watch_clear("clear command");
		f0 = fetch_total;
		send_request(2, 3, 8);
		drop_request();
		wait_drain();
		check_count("fetches after clear", 1, fetch_total - f0);

		check_count("hit strobes", ref_hits, dut_hits);
		check_count("miss strobes", ref_misses, dut_misses);
		check_count("range strobes", ref_ranges, dut_ranges);
		check_count("address transfers", ref_misses, fetch_total);
		check_count("last beats", fetch_total, last_total);
		$display("errors: %0d value mismatches, %0d other failures", value_errs, other_errs);
		if (value_errs == 0 && other_errs == 0) begin
			$display("Simulation PASSED");
		end else begin
			$display("Simulation FAILED");
		end
		$finish;
	end

endmodule

// ==== files.f ====
hw/tex_cache_pkg.sv
hw/tex_fifo.sv
hw/tex_tag_lookup.sv
hw/tex_fetch_limiter.sv
hw/tex_block_store.sv
hw/tex_cache_lookahead.sv
bench/tex_mem_model.sv
bench/tb_tex_cache.sv

// ==== run.sh ====
#!/bin/sh
# build the texture cache testbench with Verilator, run it, look for the pass line
verilator --binary --timing -Wno-fatal -f files.f --top-module tb_tex_cache \
	-o tb_tex_cache &&
	./obj_dir/tb_tex_cache | tee /dev/stderr | grep -q "Simulation PASSED" &&
	echo "run ok" ||
	{ echo "run failed"; exit 1; }
